/* verilog/vpu_pkg.sv */
// Vector unit package with widths, opcode enum, command and memory structs, lane count
package vpu_pkg;

	////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////
	localparam int NUM_LANE		= 4;						// Lanes in the unit
	localparam int NUM_REG		= 8;						// Registers per lane
	localparam int LDST_CREDITS	= 2;						// Outstanding requests per lane

	localparam int DATA_W		= 32;						// Data word
	localparam int ADDR_W		= 16;						// Word address
	localparam int REG_W		= $clog2(NUM_REG);			// Register index
	localparam int CREDIT_W		= $clog2(LDST_CREDITS + 1);	// Counter holds 0..LDST_CREDITS

	////////////////////////////////////////////////////////////
	// Plain vector types
	////////////////////////////////////////////////////////////
	typedef logic [DATA_W-1:0]		data_t;					// Lane data
	typedef logic [ADDR_W-1:0]		addr_t;					// Memory word address
	typedef logic [REG_W-1:0]		reg_idx_t;				// Register index
	typedef logic [NUM_LANE-1:0]	lane_t;					// One bit per lane
	typedef logic [CREDIT_W-1:0]	credit_t;				// Memory credit count

	////////////////////////////////////////////////////////////
	// Operations
	////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		OP_ADD	= 4'h0,										// dst = src1 + src2
		OP_SUB	= 4'h1,										// dst = src1 - src2
		OP_AND	= 4'h2,										// dst = src1 & src2
		OP_XOR	= 4'h3,										// dst = src1 ^ src2
		OP_ADDS	= 4'h4,										// dst = src1 + scalar
		OP_MOVS	= 4'h5,										// dst = scalar
		OP_ROT	= 4'h6,										// dst = src1 of next lane up
		OP_RDS	= 4'h7,										// scalar out = src1
		OP_LD	= 4'h8,										// dst = mem[src1]
		OP_ST	= 4'h9										// mem[src1] = src2
	} v_op_t;

	// Broadcast command
	typedef struct packed {
		v_op_t		op;										// Operation
		reg_idx_t	dst;									// Destination register
		reg_idx_t	src1;									// First source, also address
		reg_idx_t	src2;									// Second source, also store data
	} v_command_t;

	// Request toward memory
	typedef struct packed {
		logic		valid;									// Request this cycle
		logic		store;									// 1 store, 0 load
		addr_t		addr;									// Word address
		data_t		st_data;								// Store payload
	} v_ldst_t;

	// Load response from memory
	typedef struct packed {
		logic		valid;									// Load data present
		data_t		ld_data;								// Loaded word
	} v_ldrsp_t;

endpackage

/* verilog/lane_regfile.sv */
// Per-lane register file, two combinational read ports and one write port
`timescale 1ns/100ps

module lane_regfile
	import vpu_pkg::*;
(
	input	logic		clock,
	input	logic		rst_n,
	input	reg_idx_t	rd_idx1,							// First read index
	input	reg_idx_t	rd_idx2,							// Second read index
	output	data_t		rd_data1,							// First read data
	output	data_t		rd_data2,							// Second read data
	input	logic		wr_en,								// Write strobe
	input	reg_idx_t	wr_idx,								// Write index
	input	data_t		wr_data								// Write data
);

	data_t	regs [NUM_REG];									// Register storage

	////////////////////////////////////////////////////////////
	// Read ports
	////////////////////////////////////////////////////////////
	assign rd_data1	= regs[rd_idx1];						// Combinational read
	assign rd_data2	= regs[rd_idx2];

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REG; i++) begin
				regs[i] <= '0;								// All registers start at zero
			end
		end
		else if (wr_en) begin
			regs[wr_idx] <= wr_data;						// Visible after the edge
		end
	end

	// Same-cycle write and read returns the old value,
	// the lane never reads a register in its own write cycle

endmodule

/* verilog/lane_alu.sv */
// Per-lane integer operation unit with scalar and cross-lane operand selection
`timescale 1ns/100ps

module lane_alu
	import vpu_pkg::*;
(
	input	v_op_t		op,									// Latched operation
	input	data_t		src1,								// Register src1
	input	data_t		src2,								// Register src2
	input	data_t		scalar_in,							// Broadcast scalar
	input	data_t		rot_src,							// src1 of next lane up
	output	data_t		result,								// Write-back value
	output	logic		wr_result							// Op writes a register
);

	////////////////////////////////////////////////////////////
	// Operation select
	////////////////////////////////////////////////////////////
	always_comb begin
		result		= '0;
		wr_result	= 1'b1;									// Most ops write dst
		case (op)
			OP_ADD: begin
				result = src1 + src2;						// Wraps at 32 bits
			end
			OP_SUB: begin
				result = src1 - src2;
			end
			OP_AND: begin
				result = src1 & src2;
			end
			OP_XOR: begin
				result = src1 ^ src2;
			end
			OP_ADDS: begin
				result = src1 + scalar_in;					// Register plus scalar
			end
			OP_MOVS: begin
				result = scalar_in;							// Scalar broadcast
			end
			OP_ROT: begin
				result = rot_src;							// Cross-lane move
			end
			OP_RDS: begin
				wr_result = 1'b0;							// Read goes to scalar out
			end
			OP_LD: begin
				wr_result = 1'b0;							// Written later from response
			end
			OP_ST: begin
				wr_result = 1'b0;							// No register result
			end
			default: begin
				wr_result = 1'b0;							// Unknown code does nothing
			end
		endcase
	end

endmodule

/* verilog/lane_ldst.sv */
// Per-lane memory port with credit counter, request issue and response capture
`timescale 1ns/100ps

module lane_ldst
	import vpu_pkg::*;
(
	input	logic		clock,
	input	logic		rst_n,
	input	logic		start,								// Memory op begins
	input	v_op_t		op,									// LD or ST
	input	addr_t		addr,								// Word address
	input	data_t		st_data,							// Store payload
	output	v_ldst_t	ldst_req,							// Request to memory
	input	v_ldrsp_t	ldst_rsp,							// Load response
	input	logic		credit_ret,							// One credit back
	output	logic		ld_valid,							// Load data for write-back
	output	data_t		ld_data,
	output	logic		done								// Memory op complete
);

	////////////////////////////////////////////////////////////
	// Pending request
	////////////////////////////////////////////////////////////
	logic		pend_q;										// Request waiting for issue
	logic		ld_wait_q;									// Load issued, no data yet
	logic		store_q;									// Held request kind
	addr_t		addr_q;										// Held address
	data_t		data_q;										// Held store data
	credit_t	credits;									// Credits on hand
	logic		issue;										// Request leaves this cycle

	assign issue = pend_q && (credits != '0);				// Needs at least one credit

	// Payload captured at start
	always_ff @(posedge clock) begin
		if (start) begin
			store_q	<= (op == OP_ST);
			addr_q	<= addr;
			data_q	<= st_data;
		end
	end

	////////////////////////////////////////////////////////////
	// Control and credits
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pend_q		<= 1'b0;
			ld_wait_q	<= 1'b0;
			credits		<= CREDIT_W'(LDST_CREDITS);			// Full pool after reset
		end
		else begin
			if (start) begin
				pend_q <= 1'b1;
			end
			else if (issue) begin
				pend_q <= 1'b0;								// Single-cycle request
			end
			if (issue && !store_q) begin
				ld_wait_q <= 1'b1;							// Await load data
			end
			else if (ldst_rsp.valid) begin
				ld_wait_q <= 1'b0;
			end
			credits <= credits - CREDIT_W'(issue) + CREDIT_W'(credit_ret);
		end
	end

	////////////////////////////////////////////////////////////
	// Request and completion
	////////////////////////////////////////////////////////////
	always_comb begin
		ldst_req.valid		= issue;
		ldst_req.store		= store_q;
		ldst_req.addr		= addr_q;
		ldst_req.st_data	= data_q;
	end

	assign ld_valid	= ld_wait_q & ldst_rsp.valid;			// Only the awaited response
	assign ld_data	= ldst_rsp.ld_data;
	assign done		= (issue & store_q) | ld_valid;		// Store at issue, load at data

endmodule

/* verilog/lane_unit.sv */
// One vector lane with register file, ALU, memory port, commit flag and zero status
`timescale 1ns/100ps

module lane_unit
	import vpu_pkg::*;
#(
	parameter int LANE_ID = 0								// Position in the unit
)(
	input	logic		clock,
	input	logic		rst_n,
	input	logic		cmd_valid,							// Command broadcast
	input	logic		en,									// This lane executes
	input	v_command_t	command,
	input	data_t		scalar_in,							// Broadcast scalar
	input	data_t		lane_src_in [NUM_LANE],				// src1 of every lane
	output	data_t		lane_src_out,						// Own src1 onto the bus
	output	data_t		scalar_lane,						// Value for scalar out
	output	v_ldst_t	ldst_req,
	input	v_ldrsp_t	ldst_rsp,
	input	logic		credit_ret,
	output	logic		commit,								// Command done in this lane
	output	logic		zero								// Last write was zero
);

	localparam int ROT_LANE = (LANE_ID + 1) % NUM_LANE;	// Rotate source lane

	v_command_t	cmd_q;										// Latched command
	logic		exec_q;										// Execute cycle for this lane
	logic		commit_q;
	logic		zero_q;
	data_t		rd_data1;
	data_t		rd_data2;
	data_t		alu_result;
	logic		wr_result;
	logic		is_mem;										// LD or ST
	logic		ld_valid;
	data_t		ld_data;
	logic		ldst_done;
	logic		wr_en;
	data_t		wr_data;

	////////////////////////////////////////////////////////////
	// Command latch
	////////////////////////////////////////////////////////////
	// Every lane latches the command so a disabled lane still
	// offers the right src1 to its rotate neighbour
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			cmd_q	<= '0;
			exec_q	<= 1'b0;
		end
		else begin
			if (cmd_valid) begin
				cmd_q <= command;
			end
			exec_q <= cmd_valid & en;						// One-cycle execute pulse
		end
	end

	assign is_mem = (cmd_q.op == OP_LD) || (cmd_q.op == OP_ST);

	lane_regfile rf0 (
		.clock		(clock),
		.rst_n		(rst_n),
		.rd_idx1	(cmd_q.src1),
		.rd_idx2	(cmd_q.src2),
		.rd_data1	(rd_data1),
		.rd_data2	(rd_data2),
		.wr_en		(wr_en),
		.wr_idx		(cmd_q.dst),
		.wr_data	(wr_data)
	);

	lane_alu alu0 (
		.op			(cmd_q.op),
		.src1		(rd_data1),
		.src2		(rd_data2),
		.scalar_in	(scalar_in),
		.rot_src	(lane_src_in[ROT_LANE]),				// Next lane up, wrapping
		.result		(alu_result),
		.wr_result	(wr_result)
	);

	lane_ldst ldst0 (
		.clock		(clock),
		.rst_n		(rst_n),
		.start		(exec_q & is_mem),
		.op			(cmd_q.op),
		.addr		(rd_data1[ADDR_W-1:0]),				// Address from src1
		.st_data	(rd_data2),								// Store data from src2
		.ldst_req	(ldst_req),
		.ldst_rsp	(ldst_rsp),
		.credit_ret	(credit_ret),
		.ld_valid	(ld_valid),
		.ld_data	(ld_data),
		.done		(ldst_done)
	);

	////////////////////////////////////////////////////////////
	// Write-back, commit, status
	////////////////////////////////////////////////////////////
	assign wr_en	= (exec_q & wr_result) | ld_valid;		// ALU or load response
	assign wr_data	= ld_valid ? ld_data : alu_result;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			commit_q	<= 1'b0;
			zero_q		<= 1'b0;
		end
		else begin
			if (cmd_valid) begin
				commit_q <= 1'b0;							// New command starts
			end
			else if ((exec_q & ~is_mem) | ldst_done) begin
				commit_q <= 1'b1;
			end
			if (wr_en) begin
				zero_q <= (wr_data == '0);					// Tracks each write
			end
		end
	end

	assign commit		= commit_q;
	assign zero			= zero_q;
	assign lane_src_out	= rd_data1;
	assign scalar_lane	= rd_data1;							// OP_RDS reads src1

endmodule

/* verilog/vector_unit.sv */
// SIMT vector unit top with lane generation, cross-lane bus, commit and scalar select
`timescale 1ns/100ps

module vector_unit
	import vpu_pkg::*;
(
	input	logic		clock,
	input	logic		rst_n,
	input	logic		cmd_valid,							// Command strobe
	input	v_command_t	command,							// Broadcast command
	input	lane_t		en_lane,							// Lane enable mask
	input	data_t		scalar_in,							// Broadcast scalar
	output	data_t		scalar_out,							// From lowest enabled lane
	output	logic		commit_req,							// Command finished
	output	lane_t		status,								// Per-lane zero flag
	output	v_ldst_t	ldst_req [NUM_LANE],				// Memory requests
	input	v_ldrsp_t	ldst_rsp [NUM_LANE],				// Load responses
	input	lane_t		credit_ret							// Credit returns
);

	lane_t	en_lane_q;										// Mask of the running command
	logic	issued_q;										// Command outstanding
	lane_t	commit;											// Lane commit bits
	data_t	lane_src [NUM_LANE];							// Cross-lane src1 bus
	data_t	scalar_lane [NUM_LANE];							// Per-lane scalar candidates

	////////////////////////////////////////////////////////////
	// Issue and commit
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			en_lane_q	<= '0;
			issued_q	<= 1'b0;
		end
		else if (cmd_valid) begin
			en_lane_q	<= en_lane;
			issued_q	<= 1'b1;
		end
		else if (commit_req) begin
			issued_q	<= 1'b0;							// One-cycle commit pulse
		end
	end

	// Every lane agrees with the mask, disabled lanes sit at zero
	assign commit_req = issued_q & (&(~(en_lane_q ^ commit)));

	// Lowest enabled lane wins
	always_comb begin
		scalar_out = '0;
		for (int i = NUM_LANE - 1; i >= 0; i--) begin
			if (en_lane_q[i]) begin
				scalar_out = scalar_lane[i];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Lanes
	////////////////////////////////////////////////////////////
	for (genvar i = 0; i < NUM_LANE; i++) begin : lane_g
		lane_unit #(
			.LANE_ID		(i)
		) lane0 (
			.clock			(clock),
			.rst_n			(rst_n),
			.cmd_valid		(cmd_valid),
			.en				(en_lane[i]),
			.command		(command),
			.scalar_in		(scalar_in),
			.lane_src_in	(lane_src),						// Whole bus to every lane
			.lane_src_out	(lane_src[i]),
			.scalar_lane	(scalar_lane[i]),
			.ldst_req		(ldst_req[i]),
			.ldst_rsp		(ldst_rsp[i]),
			.credit_ret		(credit_ret[i]),
			.commit			(commit[i]),
			.zero			(status[i])
		);
	end

endmodule

/* sim/vector_unit_props.sv */
// Concurrent checks on commit pulse, memory credits and reset state of the vector unit
`timescale 1ns/100ps

module vector_unit_props
	import vpu_pkg::*;
(
	input	logic		clock,
	input	logic		rst_n,
	input	logic		cmd_valid,
	input	logic		commit_req,
	input	lane_t		status,
	input	v_ldst_t	ldst_req [NUM_LANE],
	input	lane_t		credit_ret
);

	credit_t	cred_shadow [NUM_LANE];						// Credits each lane should hold
	logic		cmd_open;									// Command waiting for commit
	lane_t		req_valid;									// Valid bits of all lanes

	always_comb begin
		for (int i = 0; i < NUM_LANE; i++) begin
			req_valid[i] = ldst_req[i].valid;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			cmd_open <= 1'b0;
			for (int i = 0; i < NUM_LANE; i++) begin
				cred_shadow[i] <= CREDIT_W'(LDST_CREDITS);	// Full pool
			end
		end
		else begin
			if (cmd_valid) begin
				cmd_open <= 1'b1;
			end
			else if (commit_req) begin
				cmd_open <= 1'b0;
			end
			for (int i = 0; i < NUM_LANE; i++) begin
				cred_shadow[i] <= cred_shadow[i] - CREDIT_W'(req_valid[i])
					+ CREDIT_W'(credit_ret[i]);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Properties
	////////////////////////////////////////////////////////////
	commit_one_cycle: assert property (@(posedge clock) disable iff (!rst_n)
		commit_req |=> !commit_req)
		else $error("commit_req stayed high for more than one cycle");

	// Stale lane commits must not close a command in its issue cycle
	commit_after_cmd: assert property (@(posedge clock) disable iff (!rst_n)
		commit_req |-> (cmd_open && !$past(cmd_valid)))
		else $error("commit_req without an earlier cmd_valid");

	reset_quiet: assert property (@(posedge clock)
		!rst_n |=> (!commit_req && status == '0 && req_valid == '0))
		else $error("outputs not low after reset");

	for (genvar i = 0; i < NUM_LANE; i++) begin : cred_g
		req_has_credit: assert property (@(posedge clock) disable iff (!rst_n)
			req_valid[i] |-> (cred_shadow[i] != '0))
			else $error("memory request issued without a credit");
	end

endmodule

/* sim/tb_vector_unit.sv */
// Testbench for the vector unit with clock, reset, memory model, command driver and checks
`timescale 1ns/100ps

module tb_vector_unit;
	import vpu_pkg::*;

	logic		clock;
	logic		rst_n;
	logic		cmd_valid;
	v_command_t	command;
	lane_t		en_lane;
	data_t		scalar_in;
	data_t		scalar_out;
	logic		commit_req;
	lane_t		status;
	v_ldst_t	ldst_req [NUM_LANE];
	v_ldrsp_t	ldst_rsp [NUM_LANE];
	lane_t		credit_ret;

	integer		seed = 32'h6a9ffdf3;						// Memory delay seed
	int			cyc;										// Rising edges since start
	data_t		mem [int];									// Written words, key {lane, addr}
	int			cred_due [NUM_LANE][$];						// Cycles when credits return
	logic		rsp_pend [NUM_LANE];
	int			rsp_due [NUM_LANE];
	data_t		rsp_data [NUM_LANE];

	vector_unit dut0 (
		.clock		(clock),
		.rst_n		(rst_n),
		.cmd_valid	(cmd_valid),
		.command	(command),
		.en_lane	(en_lane),
		.scalar_in	(scalar_in),
		.scalar_out	(scalar_out),
		.commit_req	(commit_req),
		.status		(status),
		.ldst_req	(ldst_req),
		.ldst_rsp	(ldst_rsp),
		.credit_ret	(credit_ret)
	);

	bind vector_unit vector_unit_props props0 (
		.clock		(clock),
		.rst_n		(rst_n),
		.cmd_valid	(cmd_valid),
		.commit_req	(commit_req),
		.status		(status),
		.ldst_req	(ldst_req),
		.credit_ret	(credit_ret)
	);

	always #50 clock = ~clock;								// 100 ns period

	always @(posedge clock) cyc <= cyc + 1;

	// Unwritten words come from a pattern over lane and full address
	function automatic data_t read_word(int lane, addr_t a);
		int key;
		key = (lane << 16) | int'(a);
		if (mem.exists(key)) begin
			return mem[key];
		end
		return {4'(lane), 12'h0a5, a};
	endfunction

	////////////////////////////////////////////////////////////
	// Memory model
	////////////////////////////////////////////////////////////
	always @(negedge clock) begin : mem_model
		int d;
		int hit;
		for (int l = 0; l < NUM_LANE; l++) begin
			credit_ret[l]	= 1'b0;							// Single-cycle pulses
			ldst_rsp[l]		= '0;
		end
		if (rst_n) begin
			for (int l = 0; l < NUM_LANE; l++) begin
				if (ldst_req[l].valid) begin
					d = 1 + int'($unsigned($random(seed)) % 4);
					cred_due[l].push_back(cyc + d);
					if (ldst_req[l].store) begin
						mem[(l << 16) | int'(ldst_req[l].addr)] = ldst_req[l].st_data;
					end
					else begin
						rsp_pend[l]	= 1'b1;
						rsp_due[l]	= cyc + d;
						rsp_data[l]	= read_word(l, ldst_req[l].addr);
					end
				end
				if (rsp_pend[l] && rsp_due[l] <= cyc) begin
					ldst_rsp[l].valid	= 1'b1;
					ldst_rsp[l].ld_data	= rsp_data[l];
					rsp_pend[l]			= 1'b0;
				end
				hit = -1;
				for (int k = 0; k < cred_due[l].size(); k++) begin
					if (hit < 0 && cred_due[l][k] <= cyc) begin
						hit = k;
					end
				end
				if (hit >= 0) begin
					cred_due[l].delete(hit);				// One credit per cycle
					credit_ret[l] = 1'b1;
				end
			end
		end
	end

	// Waits for commit_req, returns cycles after issue or -1
	task automatic wait_commit(output int cycles);
		cycles = 0;
		while (!commit_req && cycles < 50) begin
			@(negedge clock);
			cycles++;
		end
		if (!commit_req) begin
			cycles = -1;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Command driver and checks
	////////////////////////////////////////////////////////////
	initial begin
		int			fd;
		int			n;
		int			cycles;
		int			tests;
		int			fails;
		logic		bad;
		logic		stop;
		string		line;
		string		name;
		logic [31:0]	op;
		logic [31:0]	dst;
		logic [31:0]	src1;
		logic [31:0]	src2;
		logic [31:0]	mask;
		logic [31:0]	scal;
		logic [31:0]	exp_s;
		logic [31:0]	exp_st;
		clock		= 1'b0;
		rst_n		= 1'b0;
		cyc			= 0;
		cmd_valid	= 1'b0;
		command		= '0;
		en_lane		= '0;
		scalar_in	= '0;
		credit_ret	= '0;
		tests		= 0;
		fails		= 0;
		stop		= 1'b0;
		for (int l = 0; l < NUM_LANE; l++) begin
			ldst_rsp[l]	= '0;
			rsp_pend[l]	= 1'b0;
			rsp_due[l]	= 0;
		end
		repeat (3) @(posedge clock);						// Reset for 3 cycles
		@(negedge clock);
		rst_n = 1'b1;
		fd = $fopen("sim/vector_unit_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file");
			stop = 1'b1;
		end
		while (!stop && $fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			n = $sscanf(line, "%s %h %h %h %h %h %h %h %h",
				name, op, dst, src1, src2, mask, scal, exp_s, exp_st);
			if (n != 9) begin
				$display("Malformed stimulus line: %s", line);
				fails++;
				continue;
			end
			tests++;
			bad = 1'b0;
			@(negedge clock);
			cmd_valid		= 1'b1;
			command.op		= v_op_t'(op[3:0]);
			command.dst		= reg_idx_t'(dst);
			command.src1	= reg_idx_t'(src1);
			command.src2	= reg_idx_t'(src2);
			en_lane			= lane_t'(mask);
			scalar_in		= scal;
			@(negedge clock);
			cmd_valid = 1'b0;								// Single-cycle strobe
			wait_commit(cycles);
			if (cycles < 0) begin
				$display("%s: commit_req did not arrive within 50 cycles", name);
				fails++;
				stop = 1'b1;
				continue;
			end
			if (op < 8) begin
				assert (cycles == 1) else begin
					$display("[ERROR] %s commit latency expected 1 actual %0d", name, cycles);
					bad = 1'b1;
				end
			end
			if (op == 7) begin
				assert (scalar_out == exp_s) else begin
					$display("[ERROR] %s scalar_out expected %h actual %h",
						name, exp_s, scalar_out);
					bad = 1'b1;
				end
			end
			assert (status == lane_t'(exp_st)) else begin
				$display("[ERROR] %s status expected %h actual %h",
					name, lane_t'(exp_st), status);
				bad = 1'b1;
			end
			if (bad) begin
				fails++;
				$display("%s failed", name);
			end
			else begin
				$display("%s ok", name);
			end
		end
		$display("Tests run %0d, failed %0d", tests, fails);
		if (fails == 0 && !stop) begin
			$display("ALL TESTS PASSED");
		end
		else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* sim/vector_unit_input.txt */
# name op dst src1 src2 mask scalar exp_scalar exp_status, all hex
# exp_scalar is checked for op 7 only, status for every line
rds_reset 7 0 0 0 f 0 0 0
movs_r1 5 1 0 0 f 64 0 0
movs_r2 5 2 0 0 f 1e 0 0
add_r3 0 3 1 2 f 0 0 0
rds_r3 7 0 3 0 f 0 82 0
sub_r4 1 4 1 2 f 0 0 0
rds_r4 7 0 4 0 f 0 46 0
and_r5 2 5 1 2 f 0 0 0
rds_r5 7 0 5 0 f 0 4 0
xor_zero 3 6 1 1 f 0 0 f
rds_zero 7 0 6 0 f 0 0 f
movs_l0 5 7 0 0 1 11 0 e
movs_l1 5 7 0 0 2 22 0 c
movs_l2 5 7 0 0 4 33 0 8
movs_l3 5 7 0 0 8 44 0 0
adds_l1 4 7 7 0 2 1 0 0
rds_keep_l0 7 0 7 0 1 0 11 0
rds_adds_l1 7 0 7 0 2 0 23 0
rot_r0 6 0 7 0 f 0 0 0
rds_rot_l0 7 0 0 0 1 0 23 0
rds_rot_l1 7 0 0 0 2 0 33 0
rds_rot_l2 7 0 0 0 4 0 44 0
rds_rot_l3 7 0 0 0 8 0 11 0
st_r7 9 0 1 7 f 0 0 0
st_r0 9 0 4 0 f 0 0 0
st_r3 9 0 5 3 f 0 0 0
ld_r2 8 2 1 0 f 0 0 0
rds_ld_l2 7 0 2 0 4 0 33 0
ld_r6 8 6 4 0 f 0 0 0
rds_ld_l3 7 0 6 0 8 0 11 0
ld_r5 8 5 5 0 f 0 0 0
rds_ld_l0 7 0 5 0 1 0 82 0

/* all.f */
verilog/vpu_pkg.sv
verilog/lane_regfile.sv
verilog/lane_alu.sv
verilog/lane_ldst.sv
verilog/lane_unit.sv
verilog/vector_unit.sv
sim/vector_unit_props.sv
sim/tb_vector_unit.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -f all.f --top-module tb_vector_unit -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
